//--- build.f
+incdir+include
rtl/cart_pkg.sv
rtl/host_pkg.sv
rtl/rom_header_detect.sv
rtl/ram_clear_seq.sv
rtl/backup_ram.sv
rtl/backup_sync.sv
rtl/snes_cart_ctrl.sv
sim/snes_cart_ctrl_assert.sv
sim/tb_snes_cart_ctrl.sv

//--- include/snes_cart_consts.svh
// Shared constants for the cartridge loader and the save-RAM paths
// Header offsets are image byte addresses without the copier header
// Mask widths assume size codes of at most 14
`ifndef SNES_CART_CONSTS_SVH
`define SNES_CART_CONSTS_SVH

//================================================
// Widths
`define DL_ADDR_W        25
`define WORD_W           16
`define MASK_W           24
`define CLEAR_ADDR_W     17
`define BSRAM_BITS       17
`define SD_BUF_ADDR_W    8

//================================================
// ROM header locations
`define HDR_COPIER       'h200
`define HDR_LOROM_SIZE   'h7FD6
`define HDR_LOROM_RAM    'h7FD8
`define HDR_HIROM_SIZE   'hFFD6
`define HDR_HIROM_RAM    'hFFD8
`define HDR_EXHIROM_SIZE 'h40FFD6
`define HDR_EXHIROM_RAM  'h40FFD8
// Used until a header says otherwise
`define DEFAULT_ROM_SIZE 4'hC

//================================================
// Work-RAM fill patterns
`define FILL_SNES2_A     8'h66
`define FILL_SNES2_B     8'h99
`define FILL_SNES1_A     8'hFF
`define FILL_SNES1_B     8'h00
`define FILL_SD2SNES     8'h55
`define FILL_ONES        8'hFF

`endif

//--- rtl/backup_ram.sv
// Save RAM, byte port for the console and word port for the SD buffer
// Byte 2n is the low byte of word n; both ports read with one cycle latency
// The clear overrides the console port
`timescale 1ns/100ps
`default_nettype none
`include "snes_cart_consts.svh"

module backup_ram (
	input  wire                        clk_sys,
	input  wire host_pkg::bsram_bus_t  bus,
	input  wire cart_pkg::fill_t       fill,
	input  wire                        clearing,
	input  wire host_pkg::sd_lba_t     lba,
	input  wire host_pkg::sd_buf_t     sd_buf,
	input  wire                        sd_ack,
	output cart_pkg::byte_t            q,
	output cart_pkg::word_t            sd_dout
);
	import cart_pkg::*;
	import host_pkg::*;

	localparam int WORD_BITS = `BSRAM_BITS - 1;
	localparam int LBA_BITS  = WORD_BITS - `SD_BUF_ADDR_W;

	word_t                  mem [2**WORD_BITS];
	logic [`BSRAM_BITS-1:0] a_addr;
	byte_t                  a_data;
	logic                   a_we;
	logic                   a_hi;
	word_t                  a_word;
	logic [WORD_BITS-1:0]   b_addr;
	logic                   b_we;

	assign a_addr = clearing ? fill.addr : bus.addr[`BSRAM_BITS-1:0];
	assign a_data = clearing ? `FILL_ONES : bus.data;
	assign a_we   = clearing ? fill.we : bus.we;
	// Block number picks the 512-byte window
	assign b_addr = {lba[LBA_BITS-1:0], sd_buf.addr};
	assign b_we   = sd_buf.wr & sd_ack;

	always_ff @(posedge clk_sys) begin
		if (a_we) begin
			if (a_addr[0])
				mem[a_addr[`BSRAM_BITS-1:1]][`WORD_W-1:8] <= a_data;
			else
				mem[a_addr[`BSRAM_BITS-1:1]][7:0] <= a_data;
		end
		if (b_we)
			mem[b_addr] <= sd_buf.data;
		a_word  <= mem[a_addr[`BSRAM_BITS-1:1]];
		a_hi    <= a_addr[0];
		sd_dout <= mem[b_addr];
	end

	assign q = a_hi ? a_word[`WORD_W-1:8] : a_word[7:0];

endmodule

`default_nettype wire

//--- rtl/backup_sync.sv
// Save-RAM backup control and the block sequencer towards the SD host
// rd or wr drops the cycle after ack rises; the block ends on the ack fall
// The transfer covers blocks 0 up to ram_mask[23:9]
`timescale 1ns/100ps
`default_nettype none
`include "snes_cart_consts.svh"

module backup_sync (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire cart_pkg::mask_t       ram_mask,
	input  wire cart_pkg::dl_events_t  events,
	input  wire                        cart_download,
	input  wire                        img_mounted,
	input  wire                        img_readonly,
	input  wire                        img_nonempty,
	input  wire                        bsram_we,
	input  wire                        load_req,
	input  wire                        save_req,
	input  wire                        autosave,
	input  wire                        osd_open,
	input  wire                        sd_ack,
	output host_pkg::sd_req_t          sd_req,
	output logic                       bk_loading,
	output logic                       bk_pending
);
	import cart_pkg::*;
	import host_pkg::*;

	bk_state_e state;
	mask_t     blk_last;
	logic      bk_ena;
	logic      save_lvl;
	logic      load_g;
	logic      save_g;
	logic      load_q;
	logic      save_q;
	logic      ack_q;
	logic      auto_load;
	logic      start_load;
	logic      start_xfer;

	// Last block index, one block per 512 bytes
	assign blk_last = ram_mask >> (`SD_BUF_ADDR_W + 1);

	// Autosave fires once the menu opens with unsaved data
	assign save_lvl   = save_req | (bk_pending & osd_open & autosave);
	assign load_g     = load_req & bk_ena;
	assign save_g     = save_lvl & bk_ena;
	assign auto_load  = events.done & img_nonempty & bk_ena;
	assign start_load = (load_g & ~load_q) | auto_load;
	assign start_xfer = start_load | (save_g & ~save_q);

	always_ff @(posedge clk_sys) begin
		if (RESET)
			bk_ena <= 1'b0;
		else if (events.start)
			bk_ena <= 1'b0;
		// Save image is mounted by the time the download runs
		else if (cart_download && img_mounted && !img_readonly)
			bk_ena <= |ram_mask;
	end

	always_ff @(posedge clk_sys) begin
		if (RESET)
			bk_pending <= 1'b0;
		else if (bk_ena && !osd_open && bsram_we)
			bk_pending <= 1'b1;
		else if (state == BK_XFER || !bk_ena)
			bk_pending <= 1'b0;
	end

	//================================================
	// Block sequencer
	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			state      <= BK_IDLE;
			bk_loading <= 1'b0;
			sd_req     <= '0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			load_q <= load_g;
			save_q <= save_g;
			ack_q  <= sd_ack;
			// Host took the request
			if (sd_ack && !ack_q) begin
				sd_req.rd <= 1'b0;
				sd_req.wr <= 1'b0;
			end
			case (state)
				BK_IDLE: begin
					if (start_xfer) begin
						state      <= BK_XFER;
						bk_loading <= start_load;
						sd_req.lba <= '0;
						sd_req.rd  <= start_load;
						sd_req.wr  <= ~start_load;
					end
				end
				BK_XFER: begin
					if (!sd_ack && ack_q) begin
						if (sd_req.lba >= sd_lba_t'(blk_last)) begin
							state      <= BK_IDLE;
							bk_loading <= 1'b0;
						end else begin
							sd_req.lba <= sd_req.lba + 1'b1;
							sd_req.rd  <= bk_loading;
							sd_req.wr  <= ~bk_loading;
						end
					end
				end
				default: state <= BK_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- rtl/cart_pkg.sv
// Types for the cartridge image stream, the header result and the RAM clear
// Enum encodings follow the menu option order
`default_nettype none
`include "snes_cart_consts.svh"

package cart_pkg;

	typedef logic [`DL_ADDR_W-1:0]    dl_addr_t;
	typedef logic [`WORD_W-1:0]       word_t;
	typedef logic [7:0]               byte_t;
	typedef logic [`MASK_W-1:0]       mask_t;
	typedef logic [`CLEAR_ADDR_W-1:0] clear_addr_t;

	// One host write beat of the image
	typedef struct packed {
		dl_addr_t addr;
		word_t    data;
		logic     wr;
	} dl_beat_t;

	// Edges of the download level
	typedef struct packed {
		logic start;
		logic done;
	} dl_events_t;

	typedef struct packed {
		byte_t rom_type;
		mask_t rom_mask;
		mask_t ram_mask;
	} cart_info_t;

	typedef struct packed {
		clear_addr_t addr;
		byte_t       data;
		logic        we;
	} fill_t;

	typedef enum logic [2:0] {
		HDR_AUTO    = 3'd0,
		HDR_NONE    = 3'd1,
		HDR_LOROM   = 3'd2,
		HDR_HIROM   = 3'd3,
		HDR_EXHIROM = 3'd4
	} header_mode_e;

	typedef enum logic [1:0] {
		REG_AUTO = 2'd0,
		REG_NTSC = 2'd1,
		REG_PAL  = 2'd2
	} region_mode_e;

	typedef enum logic [1:0] {
		INIT_SNES2   = 2'd0,
		INIT_SNES1   = 2'd1,
		INIT_SD2SNES = 2'd2,
		INIT_ONES    = 2'd3
	} wram_init_e;

endpackage

`default_nettype wire

//--- rtl/host_pkg.sv
// Types for the host SD block interface and the console save-RAM bus
// One SD block is 512 bytes, moved as 256 words
`default_nettype none
`include "snes_cart_consts.svh"

package host_pkg;

	typedef logic [31:0] sd_lba_t;
	typedef logic [19:0] bsram_addr_t;

	// Block request towards the host
	typedef struct packed {
		sd_lba_t lba;
		logic    rd;
		logic    wr;
	} sd_req_t;

	// Host buffer side, data flows into the save RAM
	typedef struct packed {
		logic [`SD_BUF_ADDR_W-1:0] addr;
		logic [`WORD_W-1:0]        data;
		logic                      wr;
	} sd_buf_t;

	// Console byte access
	typedef struct packed {
		bsram_addr_t addr;
		logic [7:0]  data;
		logic        we;
	} bsram_bus_t;

	typedef enum logic {
		BK_IDLE = 1'b0,
		BK_XFER = 1'b1
	} bk_state_e;

endpackage

`default_nettype wire

//--- rtl/ram_clear_seq.sv
// Work-RAM clear after a download starts, one byte per cycle
// The sweep always covers the full 17-bit space
`timescale 1ns/100ps
`default_nettype none
`include "snes_cart_consts.svh"

module ram_clear_seq (
	input  wire                        clk_sys,
	input  wire                        RESET,
	input  wire                        start,
	input  wire cart_pkg::wram_init_e  wram_init,
	output cart_pkg::fill_t            fill,
	output logic                       clearing
);
	import cart_pkg::*;

	clear_addr_t sweep_addr;
	byte_t       fill_data;

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			clearing   <= 1'b0;
			sweep_addr <= '0;
		end else begin
			if (start)
				clearing <= 1'b1;
			else if (&sweep_addr)
				clearing <= 1'b0;
			// Counter parks at zero between sweeps
			if (clearing)
				sweep_addr <= sweep_addr + 1'b1;
			else
				sweep_addr <= '0;
		end
	end

	// Power-on patterns of the different console revisions
	always_comb begin
		case (wram_init)
			INIT_SNES2: fill_data = (sweep_addr[8] ^ sweep_addr[2]) ? `FILL_SNES2_A : `FILL_SNES2_B;
			INIT_SNES1: fill_data = (sweep_addr[9] ^ sweep_addr[0]) ? `FILL_SNES1_A : `FILL_SNES1_B;
			INIT_SD2SNES: fill_data = `FILL_SD2SNES;
			default: fill_data = `FILL_ONES;
		endcase
	end

	assign fill = '{addr: sweep_addr, data: fill_data, we: clearing};

endmodule

`default_nettype wire

//--- rtl/rom_header_detect.sv
// Header detection on the download stream; only write beats during download count
// Masks follow the size registers one write beat later
`timescale 1ns/100ps
`default_nettype none
`include "snes_cart_consts.svh"

module rom_header_detect (
	input  wire                          clk_sys,
	input  wire                          RESET,
	input  wire cart_pkg::dl_beat_t      dl,
	input  wire                          cart_download,
	input  wire cart_pkg::header_mode_e  header_mode,
	input  wire cart_pkg::region_mode_e  region_mode,
	output cart_pkg::cart_info_t         info,
	output logic                         pal,
	output cart_pkg::dl_events_t         events
);
	import cart_pkg::*;

	localparam dl_addr_t LO_SIZE_AT = dl_addr_t'(`HDR_LOROM_SIZE + `HDR_COPIER);
	localparam dl_addr_t LO_RAM_AT  = dl_addr_t'(`HDR_LOROM_RAM + `HDR_COPIER);
	localparam dl_addr_t HI_SIZE_AT = dl_addr_t'(`HDR_HIROM_SIZE + `HDR_COPIER);
	localparam dl_addr_t HI_RAM_AT  = dl_addr_t'(`HDR_HIROM_RAM + `HDR_COPIER);
	localparam dl_addr_t EX_SIZE_AT = dl_addr_t'(`HDR_EXHIROM_SIZE + `HDR_COPIER);
	localparam dl_addr_t EX_RAM_AT  = dl_addr_t'(`HDR_EXHIROM_RAM + `HDR_COPIER);

	logic [3:0] rom_size;
	logic [3:0] ram_size;
	logic       rom_region;
	logic       dl_prev;
	logic       beat;
	logic       hdr_fixed;
	dl_addr_t   size_at;
	dl_addr_t   ram_at;

	assign beat = cart_download & dl.wr;
	assign events = '{start: cart_download & ~dl_prev, done: ~cart_download & dl_prev};

	// Where the forced header modes find their size bytes
	always_comb begin
		hdr_fixed = 1'b1;
		size_at   = LO_SIZE_AT;
		ram_at    = LO_RAM_AT;
		case (header_mode)
			HDR_HIROM: begin
				size_at = HI_SIZE_AT;
				ram_at  = HI_RAM_AT;
			end
			HDR_EXHIROM: begin
				size_at = EX_SIZE_AT;
				ram_at  = EX_RAM_AT;
			end
			HDR_LOROM: hdr_fixed = 1'b1;
			default: hdr_fixed = 1'b0;
		endcase
	end

	always_ff @(posedge clk_sys) begin
		if (RESET) begin
			dl_prev    <= 1'b0;
			rom_size   <= `DEFAULT_ROM_SIZE;
			ram_size   <= 4'd0;
			rom_region <= 1'b0;
			info       <= '0;
			pal        <= 1'b0;
		end else begin
			dl_prev <= cart_download;
			if (beat) begin
				if (dl.addr == '0) begin
					rom_size <= `DEFAULT_ROM_SIZE;
					ram_size <= 4'd0;
					// Copier-style size byte in front of the image
					if (header_mode == HDR_AUTO && dl.data[7:0] != 8'd0)
						{ram_size, rom_size} <= dl.data[7:0];
					case (header_mode)
						HDR_NONE, HDR_LOROM: info.rom_type <= 8'd0;
						HDR_HIROM: info.rom_type <= 8'd1;
						HDR_EXHIROM: info.rom_type <= 8'd2;
						default: info.rom_type <= dl.data[15:8];
					endcase
				end
				if (dl.addr == dl_addr_t'(2))
					rom_region <= dl.data[8];
				if (hdr_fixed && dl.addr == size_at)
					rom_size <= dl.data[11:8];
				if (hdr_fixed && dl.addr == ram_at)
					ram_size <= dl.data[3:0];
				info.rom_mask <= (mask_t'(1024) << rom_size) - mask_t'(1);
				info.ram_mask <= (ram_size != 4'd0) ?
					(mask_t'(1024) << ram_size) - mask_t'(1) : '0;
			end else if (!cart_download) begin
				pal <= (region_mode == REG_AUTO) ? rom_region : (region_mode == REG_PAL);
			end
		end
	end

endmodule

`default_nettype wire

//--- rtl/snes_cart_ctrl.sv
// Cartridge loading side of the console core
// Menu settings arrive as plain levels and must stay stable during a download
// Console and SD buffer share the save RAM through separate ports
`timescale 1ns/100ps
`default_nettype none

module snes_cart_ctrl (
	input  wire                          clk_sys,
	input  wire                          RESET,
	// Image download
	input  wire cart_pkg::dl_beat_t      dl,
	input  wire                          cart_download,
	// Menu settings
	input  wire cart_pkg::header_mode_e  header_mode,
	input  wire cart_pkg::region_mode_e  region_mode,
	input  wire cart_pkg::wram_init_e    wram_init,
	input  wire                          bk_load_req,
	input  wire                          bk_save_req,
	input  wire                          autosave,
	input  wire                          osd_open,
	// Save image and SD host
	input  wire                          img_mounted,
	input  wire                          img_readonly,
	input  wire                          img_nonempty,
	input  wire                          sd_ack,
	input  wire host_pkg::sd_buf_t       sd_buf,
	// Console save-RAM bus
	input  wire host_pkg::bsram_bus_t    bsram,
	output wire cart_pkg::cart_info_t    info,
	output wire                          pal,
	output wire cart_pkg::fill_t         fill,
	output wire                          clearing,
	output wire host_pkg::sd_req_t       sd_req,
	output wire cart_pkg::word_t         sd_buf_din,
	output wire cart_pkg::byte_t         bsram_q,
	output wire                          bk_loading,
	output wire                          bk_pending
);
	import cart_pkg::*;
	import host_pkg::*;

	wire dl_events_t events;

	rom_header_detect u_header (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.dl            (dl),
		.cart_download (cart_download),
		.header_mode   (header_mode),
		.region_mode   (region_mode),
		.info          (info),
		.pal           (pal),
		.events        (events)
	);

	ram_clear_seq u_clear (
		.clk_sys   (clk_sys),
		.RESET     (RESET),
		.start     (events.start),
		.wram_init (wram_init),
		.fill      (fill),
		.clearing  (clearing)
	);

	// Save RAM, cleared together with the work RAM
	backup_ram u_bsram (
		.clk_sys  (clk_sys),
		.bus      (bsram),
		.fill     (fill),
		.clearing (clearing),
		.lba      (sd_req.lba),
		.sd_buf   (sd_buf),
		.sd_ack   (sd_ack),
		.q        (bsram_q),
		.sd_dout  (sd_buf_din)
	);

	backup_sync u_backup (
		.clk_sys       (clk_sys),
		.RESET         (RESET),
		.ram_mask      (info.ram_mask),
		.events        (events),
		.cart_download (cart_download),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_nonempty  (img_nonempty),
		.bsram_we      (bsram.we),
		.load_req      (bk_load_req),
		.save_req      (bk_save_req),
		.autosave      (autosave),
		.osd_open      (osd_open),
		.sd_ack        (sd_ack),
		.sd_req        (sd_req),
		.bk_loading    (bk_loading),
		.bk_pending    (bk_pending)
	);

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# Build and run the cartridge loader testbench with Verilator
# The exit status follows the pass message in the simulation output

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f build.f --top-module tb_snes_cart_ctrl -o tb_sim \
	&& ./obj_dir/tb_sim | tee /dev/stderr | grep -q "ALL TESTS PASSED" \
	&& echo "run_sim: simulation passed" \
	|| { echo "run_sim: simulation failed"; exit 1; }

//--- sim/snes_cart_ctrl_assert.sv
// Protocol checks on the top level, attached by bind
// Reads the backup enable from inside the backup sequencer
`timescale 1ns/100ps
`default_nettype none
`include "snes_cart_consts.svh"

module snes_cart_ctrl_assert (
	input  wire                     clk_sys,
	input  wire                     RESET,
	input  wire host_pkg::sd_req_t  sd_req,
	input  wire cart_pkg::fill_t    fill,
	input  wire                     bk_ena,
	input  wire                     bk_pending
);
	import cart_pkg::*;
	import host_pkg::*;

	// Only one transfer direction at a time
	rd_wr_exclusive: assert property (@(posedge clk_sys) disable iff (RESET)
		!(sd_req.rd && sd_req.wr))
		else $error("sd_req.rd and sd_req.wr high together");

	// Sweep address counts up by one per fill write
	fill_addr_step: assert property (@(posedge clk_sys) disable iff (RESET)
		(fill.we && $past(fill.we)) |-> (fill.addr == clear_addr_t'($past(fill.addr) + 1'b1)))
		else $error("fill address did not step by one");

	pending_needs_enable: assert property (@(posedge clk_sys) disable iff (RESET)
		!bk_ena |=> !bk_pending)
		else $error("bk_pending high while backup is disabled");

endmodule

bind snes_cart_ctrl snes_cart_ctrl_assert u_assert (
	.clk_sys    (clk_sys),
	.RESET      (RESET),
	.sd_req     (sd_req),
	.fill       (fill),
	.bk_ena     (u_backup.bk_ena),
	.bk_pending (bk_pending)
);

`default_nettype wire

//--- sim/tb_snes_cart_ctrl.sv
// Testbench for the cartridge loader; one process drives, models the SD host and checks
// Save and load tests use a 2 KB save RAM, so the SD block number stays below 4
`timescale 1ns/100ps
`default_nettype none
`include "snes_cart_consts.svh"

module tb_snes_cart_ctrl;
	import cart_pkg::*;
	import host_pkg::*;

	localparam int CLEAR_LEN  = 1 << `CLEAR_ADDR_W;
	localparam int SAVE_BYTES = 2048;

	logic clk_sys, RESET, cart_download, img_mounted, img_readonly, img_nonempty;
	logic bk_load_req, bk_save_req, autosave, osd_open, sd_ack;
	dl_beat_t     dl;
	header_mode_e header_mode;
	region_mode_e region_mode;
	wram_init_e   wram_init;
	sd_buf_t      sd_buf;
	bsram_bus_t   bsram;
	cart_info_t   info;
	fill_t        fill;
	sd_req_t      sd_req;
	word_t        sd_buf_din;
	byte_t        bsram_q;
	logic         pal, clearing, bk_loading, bk_pending;

	int          err_count, chk_count, fill_cnt;
	int          host_phase, host_wait, host_idx, host_blocks, xfer_base;
	logic        host_load;
	logic        xfer_load;
	sd_lba_t     host_lba;
	clear_addr_t fill_exp;
	logic [31:0] lfsr_state;
	byte_t       exp_ram [SAVE_BYTES];
	word_t       load_words [SAVE_BYTES/2];

	snes_cart_ctrl snes_cart_ctrl_inst (.*);

	initial clk_sys = 1'b0;
	always #50 clk_sys = ~clk_sys;

	//==================================================
	// Random source and reference rules
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_next(lfsr_state);
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	function automatic mask_t ref_mask(input logic [3:0] code, input logic is_ram);
		logic [31:0] full;
		full = (32'd1024 << code) - 32'd1;
		if (is_ram && code == 4'd0)
			return '0;
		return full[23:0];
	endfunction

	function automatic byte_t ref_rom_type(input header_mode_e hm, input byte_t hi);
		case (hm)
			HDR_AUTO:    return hi;
			HDR_HIROM:   return 8'd1;
			HDR_EXHIROM: return 8'd2;
			default:     return 8'd0;
		endcase
	endfunction

	function automatic logic ref_pal(input region_mode_e rm, input logic bit8);
		if (rm == REG_AUTO)
			return bit8;
		return rm == REG_PAL;
	endfunction

	function automatic byte_t ref_fill(input wram_init_e m, input clear_addr_t a);
		case (m)
			INIT_SNES2:   return (a[8] ^ a[2]) ? `FILL_SNES2_A : `FILL_SNES2_B;
			INIT_SNES1:   return (a[9] ^ a[0]) ? `FILL_SNES1_A : `FILL_SNES1_B;
			INIT_SD2SNES: return `FILL_SD2SNES;
			default:      return `FILL_ONES;
		endcase
	endfunction

	//==================================================
	// Compare tasks
	task automatic cmp_mask(input string name, input mask_t got, input mask_t exp);
		chk_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic cmp_byte(input string name, input byte_t got, input byte_t exp);
		chk_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic cmp_word(input string name, input word_t got, input word_t exp);
		chk_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s got %h exp %h", $time, name, got, exp);
		end
	endtask

	task automatic cmp_bit(input string name, input logic got, input logic exp);
		chk_count++;
		if (got !== exp) begin
			err_count++;
			$display("ERR t=%0t %s got %b exp %b", $time, name, got, exp);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout: %s did not happen in time", what);
		$display("SOME TESTS FAILED");
		$finish;
	endtask

	//==================================================
	// Per-cycle fill monitor and SD host model
	task automatic fill_step();
		if (RESET) begin
			fill_cnt = 0;
			fill_exp = '0;
		end else if (fill.we) begin
			cmp_mask("fill.addr", mask_t'(fill.addr), mask_t'(fill_exp));
			cmp_byte("fill.data", fill.data, ref_fill(wram_init, fill_exp));
			fill_exp = fill_exp + 1'b1;
			fill_cnt++;
		end else if (fill_cnt != 0) begin
			cmp_mask("fill write count", mask_t'(fill_cnt), mask_t'(CLEAR_LEN));
			fill_cnt = 0;
			fill_exp = '0;
		end
	endtask

	task automatic host_step();
		int n;
		if (!RESET) begin
			case (host_phase)
				0: if (sd_req.rd || sd_req.wr) begin
					cmp_word("sd_req.lba", word_t'(sd_req.lba), word_t'(host_blocks - xfer_base));
					cmp_bit("sd_req.rd", sd_req.rd, xfer_load);
					cmp_bit("bk_loading", bk_loading, xfer_load);
					host_load  = sd_req.rd;
					host_lba   = sd_req.lba;
					host_wait  = 3;
					host_blocks++;
					host_phase = 1;
				end
				1: if (host_wait == 0) begin
					sd_ack     = 1'b1;
					host_idx   = 0;
					host_phase = 2;
				end else begin
					host_wait--;
				end
				default: begin
					n = int'(host_lba[1:0]) * 256 + host_idx;
					// Read data trails the buffer address by one cycle
					if (!host_load && host_idx > 0)
						cmp_word("sd_buf_din", sd_buf_din, {exp_ram[2*n-1], exp_ram[2*n-2]});
					if (host_idx < 256) begin
						sd_buf.addr = 8'(host_idx);
						sd_buf.wr   = host_load;
						sd_buf.data = host_load ? load_words[n] : '0;
						host_idx++;
					end else begin
						sd_buf.wr  = 1'b0;
						sd_ack     = 1'b0;
						host_phase = 0;
					end
				end
			endcase
		end
	endtask

	task automatic tick();
		@(negedge clk_sys);
		fill_step();
		host_step();
	endtask

	//==================================================
	// Download and test sequences
	task automatic put_beat(input dl_addr_t a, input word_t d);
		dl = '{addr: a, data: d, wr: 1'b1};
		tick();
	endtask

	task automatic run_download(input header_mode_e hm, input word_t w0, input word_t w2,
			input dl_addr_t size_at, input word_t size_w, input dl_addr_t ram_at, input word_t ram_w);
		logic [31:0] r;
		int n;
		header_mode   = hm;
		cart_download = 1'b1;
		put_beat('0, w0);
		put_beat(dl_addr_t'(2), w2);
		put_beat(size_at, size_w);
		put_beat(ram_at, ram_w);
		for (int i = 1; i <= 4; i++) begin
			take_bits(16, r);
			put_beat(ram_at + dl_addr_t'(2 * i), r[15:0]);
		end
		dl.wr = 1'b0;
		// Download stays high until the RAM clear is over
		n = 0;
		while (clearing && n < CLEAR_LEN + 64) begin
			tick();
			n++;
		end
		if (clearing)
			abort_on_timeout("end of the RAM clear");
		cart_download = 1'b0;
		tick();
	endtask

	task automatic check_region(input region_mode_e rm, input logic bit8);
		region_mode = rm;
		tick();
		tick();
		cmp_bit("pal", pal, ref_pal(rm, bit8));
	endtask

	task automatic header_case(input header_mode_e hm, input wram_init_e wi, input dl_addr_t size_at,
			input dl_addr_t ram_at, input logic [3:0] rom_c, input logic [3:0] ram_c);
		logic [31:0] r;
		word_t w0, w2, sw, rw;
		take_bits(16, r);
		w0 = r[15:0];
		if (hm == HDR_AUTO)
			w0[7:0] = {ram_c, rom_c};
		take_bits(16, r);
		w2 = r[15:0];
		take_bits(16, r);
		sw = r[15:0];
		sw[11:8] = rom_c;
		take_bits(16, r);
		rw = r[15:0];
		rw[3:0] = ram_c;
		wram_init = wi;
		run_download(hm, w0, w2, size_at, sw, ram_at, rw);
		cmp_byte("info.rom_type", info.rom_type, ref_rom_type(hm, w0[15:8]));
		cmp_mask("info.rom_mask", info.rom_mask, ref_mask(rom_c, 1'b0));
		cmp_mask("info.ram_mask", info.ram_mask, ref_mask(ram_c, 1'b1));
		check_region(REG_AUTO, w2[8]);
		check_region(REG_NTSC, w2[8]);
		check_region(REG_PAL, w2[8]);
	endtask

	task automatic save_test();
		logic [31:0] r;
		int a;
		int n;
		img_mounted  = 1'b1;
		img_nonempty = 1'b0;
		xfer_load    = 1'b0;
		header_case(HDR_LOROM, INIT_SNES2, dl_addr_t'(`HDR_LOROM_SIZE + `HDR_COPIER),
			dl_addr_t'(`HDR_LOROM_RAM + `HDR_COPIER), 4'h8, 4'h1);
		for (int i = 0; i < SAVE_BYTES; i++)
			exp_ram[i] = `FILL_ONES;
		cmp_bit("bk_pending", bk_pending, 1'b0);
		for (int i = 0; i < 8; i++) begin
			take_bits(11, r);
			a = int'(r[10:0]);
			take_bits(8, r);
			exp_ram[a] = r[7:0];
			bsram = '{addr: bsram_addr_t'(a), data: r[7:0], we: 1'b1};
			tick();
			bsram.we = 1'b0;
			tick();
		end
		cmp_bit("bk_pending", bk_pending, 1'b1);
		xfer_base   = host_blocks;
		bk_save_req = 1'b1;
		repeat (3) tick();
		bk_save_req = 1'b0;
		n = 0;
		while ((host_blocks - xfer_base < 4 || host_phase != 0) && n < 20000) begin
			tick();
			n++;
		end
		if (host_blocks - xfer_base < 4 || host_phase != 0)
			abort_on_timeout("the four save blocks");
		// A fifth request would show up in the block count here
		repeat (8) tick();
		cmp_word("save block count", word_t'(host_blocks - xfer_base), 16'd4);
		cmp_bit("sd_req.wr", sd_req.wr, 1'b0);
		cmp_bit("bk_pending", bk_pending, 1'b0);
	endtask

	task automatic load_test();
		logic [31:0] r;
		int a;
		int n;
		for (int i = 0; i < SAVE_BYTES / 2; i++) begin
			take_bits(16, r);
			load_words[i] = r[15:0];
		end
		img_nonempty = 1'b1;
		xfer_load    = 1'b1;
		xfer_base    = host_blocks;
		header_case(HDR_LOROM, INIT_SNES1, dl_addr_t'(`HDR_LOROM_SIZE + `HDR_COPIER),
			dl_addr_t'(`HDR_LOROM_RAM + `HDR_COPIER), 4'h8, 4'h1);
		// Region checks above may already cover the start of the load
		n = 0;
		while (!bk_loading && host_blocks == xfer_base && n < 100) begin
			tick();
			n++;
		end
		if (!bk_loading && host_blocks == xfer_base)
			abort_on_timeout("start of the autoload");
		n = 0;
		while (bk_loading && n < 20000) begin
			tick();
			n++;
		end
		if (bk_loading)
			abort_on_timeout("end of the autoload");
		cmp_word("load block count", word_t'(host_blocks - xfer_base), 16'd4);
		for (int i = 0; i < SAVE_BYTES / 2; i++) begin
			exp_ram[2*i]   = load_words[i][7:0];
			exp_ram[2*i+1] = load_words[i][15:8];
		end
		for (int i = 0; i < 16; i++) begin
			take_bits(11, r);
			a = int'(r[10:0]);
			bsram = '{addr: bsram_addr_t'(a), data: 8'h00, we: 1'b0};
			tick();
			cmp_byte("bsram_q", bsram_q, exp_ram[a]);
		end
	endtask

	//==================================================
	initial begin
		err_count     = 0;
		chk_count     = 0;
		fill_cnt      = 0;
		fill_exp      = '0;
		host_phase    = 0;
		host_wait     = 0;
		host_idx      = 0;
		host_blocks   = 0;
		xfer_base     = 0;
		host_load     = 1'b0;
		xfer_load     = 1'b0;
		host_lba      = '0;
		lfsr_state    = 32'h47051889;
		RESET         = 1'b1;
		dl            = '0;
		cart_download = 1'b0;
		header_mode   = HDR_AUTO;
		region_mode   = REG_AUTO;
		wram_init     = INIT_SNES2;
		img_mounted   = 1'b0;
		img_readonly  = 1'b0;
		img_nonempty  = 1'b0;
		bk_load_req   = 1'b0;
		bk_save_req   = 1'b0;
		autosave      = 1'b0;
		osd_open      = 1'b0;
		sd_ack        = 1'b0;
		sd_buf        = '0;
		bsram         = '0;
		repeat (16) tick();
		RESET = 1'b0;
		tick();
		cmp_bit("clearing", clearing, 1'b0);
		cmp_bit("fill.we", fill.we, 1'b0);
		cmp_bit("sd_req.rd", sd_req.rd, 1'b0);
		cmp_bit("sd_req.wr", sd_req.wr, 1'b0);
		cmp_bit("bk_loading", bk_loading, 1'b0);
		cmp_bit("bk_pending", bk_pending, 1'b0);

		header_case(HDR_AUTO, INIT_SNES2, dl_addr_t'(`HDR_LOROM_SIZE + `HDR_COPIER),
			dl_addr_t'(`HDR_LOROM_RAM + `HDR_COPIER), 4'hA, 4'h3);
		header_case(HDR_LOROM, INIT_SNES1, dl_addr_t'(`HDR_LOROM_SIZE + `HDR_COPIER),
			dl_addr_t'(`HDR_LOROM_RAM + `HDR_COPIER), 4'h9, 4'h5);
		header_case(HDR_HIROM, INIT_SD2SNES, dl_addr_t'(`HDR_HIROM_SIZE + `HDR_COPIER),
			dl_addr_t'(`HDR_HIROM_RAM + `HDR_COPIER), 4'hB, 4'h2);
		header_case(HDR_EXHIROM, INIT_ONES, dl_addr_t'(`HDR_EXHIROM_SIZE + `HDR_COPIER),
			dl_addr_t'(`HDR_EXHIROM_RAM + `HDR_COPIER), 4'hD, 4'h7);
		save_test();
		load_test();

		repeat (10) tick();
		$display("Checks run: %0d, errors: %0d", chk_count, err_count);
		if (err_count == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

`default_nettype wire
